// File: verif/rom_patterns.hex
// kind(1) slot(1) address(6) data(4), kind 0 download, 1 read, 2 cached read
// kind 3 main and object read pair, 4 read held off by downloading
000001000011
000001010022
000001020033
000001030044
0000020000A1
0000020100A2
00000300005A
000280100055
000280130066
000800200077
000800230088
000900050099
000D00400001
000D004100B2
000D004200C3
000D004300D4
000D008000E5
000D008100F6
0019000300AB
001901FF00CD
0019020000EE
100001000011
200001020033
200001030044
110000100055
210000130066
120000200077
220000230088
13000020B201
23000021D4C3
3000020000A1
33000040F6E5
40000300005A

// File: files.f
+incdir+logic
logic/game_rom_pkg.sv
logic/rom_req_if.sv
logic/rom_loader.sv
logic/rom_slot.sv
logic/rom_arbiter.sv
logic/game_rom_top.sv
verif/game_rom_sva.sv
verif/game_rom_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the game ROM testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module game_rom_tb -f files.f
./obj_dir/Vgame_rom_tb 2>&1 | tee sim.log || true
grep -q "ALL TESTS PASSED" sim.log

// File: verif/game_rom_tb.sv
// Testbench for the game ROM path with an SDRAM model and file driven checks
`timescale 1ns/1ns
`include "game_macros.svh"

module game_rom_tb;

    localparam int TMO = 400;   // Cycles per wait

    logic                      clk;
    logic                      rst_n;
    logic                      downloading;
    logic [`GAME_IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]                ioctl_dout;
    logic                      ioctl_wr;
    logic [`GAME_SDRAM_AW-1:0] prog_addr;
    logic [7:0]                prog_data;
    logic [1:0]                prog_mask;
    logic                      prog_we;
    logic                      prom_we;
    logic                      sdram_req;
    logic [`GAME_SDRAM_AW-1:0] sdram_addr;
    logic                      sdram_ack;
    logic                      data_rdy;
    logic [31:0]               data_read;
    logic                      main_cs, snd_cs, char_cs, obj_cs;
    logic [`MAIN_SLOT_AW-1:0]  main_addr;
    logic [`SND_SLOT_AW-1:0]   snd_addr;
    logic [`CHAR_SLOT_AW-1:0]  char_addr;
    logic [`OBJ_SLOT_AW-1:0]   obj_addr;
    logic [7:0]                main_data, snd_data, char_data;
    logic [15:0]               obj_data;
    logic                      main_ok, snd_ok, char_ok, obj_ok;

    logic [15:0] mem [0:(1<<`GAME_SDRAM_AW)-1];
    logic [47:0] pat [0:63];   // kind, slot, address, data
    integer      seed = 32'h393dac9f;

    game_rom_top dut_i (.*);

    always #20 clk = ~clk;

    function automatic int rnd(input int n);
        rnd = {$random(seed)} % n;
    endfunction

    // SDRAM model serving programming writes and 32-bit reads
    always begin : sdram_model
        int                        dly;
        logic [`GAME_SDRAM_AW-1:0] a;
        @(negedge clk);
        if (rst_n && prog_we) begin
            dly = rnd(6);
            repeat (dly) @(negedge clk);
            if (!prog_mask[0]) mem[prog_addr][7:0] = prog_data;
            if (!prog_mask[1]) mem[prog_addr][15:8] = prog_data;
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
        end else if (rst_n && sdram_req) begin
            a   = sdram_addr;
            assert (!a[0]) else report_failure("SDRAM read address is not an even word");
            dly = rnd(6);
            repeat (dly) @(negedge clk);
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
            dly = 1 + rnd(4);
            repeat (dly - 1) @(negedge clk);
            data_rdy  = 1'b1;
            data_read = {mem[a + 1], mem[a]};
            @(negedge clk);
            data_rdy  = 1'b0;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic game_rom_pkg::region_t region_of(input logic [24:0] a);
        if (a < `SCR_START) return game_rom_pkg::REG_CODE;
        if (a < `OBJ_START) return game_rom_pkg::REG_SCROLL;
        if (a < `PROM_START) return game_rom_pkg::REG_OBJECT;
        if (a < `ROM_END) return game_rom_pkg::REG_PROM;
        return game_rom_pkg::REG_NONE;
    endfunction

    function automatic logic [21:0] expect_prog_addr(input logic [24:0] a);
        case (region_of(a))
            game_rom_pkg::REG_SCROLL: return 22'(`SCR_SDRAM + ((a - `SCR_START) >> 1));
            game_rom_pkg::REG_OBJECT: return 22'(`OBJ_SDRAM + ((a - `OBJ_START) >> 1));
            game_rom_pkg::REG_PROM:   return 22'(a - `PROM_START);
            default:                  return 22'(a >> 1);
        endcase
    endfunction

    task automatic drive_slot(input int slot, input logic [23:0] a, input logic en);
        case (slot)
            0: begin
                main_cs   = en;
                main_addr = 18'(a);
            end
            1: begin
                snd_cs   = en;
                snd_addr = 15'(a);
            end
            2: begin
                char_cs   = en;
                char_addr = 16'(a);
            end
            default: begin
                obj_cs   = en;
                obj_addr = 19'(a);
            end
        endcase
    endtask

    function automatic logic slot_ok(input int slot);
        case (slot)
            0: return main_ok;
            1: return snd_ok;
            2: return char_ok;
            default: return obj_ok;
        endcase
    endfunction

    function automatic logic [15:0] slot_data(input int slot);
        case (slot)
            0: return {8'h00, main_data};
            1: return {8'h00, snd_data};
            2: return {8'h00, char_data};
            default: return obj_data;
        endcase
    endfunction

    function automatic string data_name(input int slot);
        case (slot)
            0: return "main_data";
            1: return "snd_data";
            2: return "char_data";
            default: return "obj_data";
        endcase
    endfunction

    task automatic download_byte(input logic [24:0] a, input logic [7:0] d);
        int                    n;
        game_rom_pkg::region_t reg_kind;
        reg_kind = region_of(a);
        @(negedge clk);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (reg_kind == game_rom_pkg::REG_NONE) begin
            assert (!prog_we && !prom_we) else report_failure("write outside the ROM map");
        end else if (reg_kind == game_rom_pkg::REG_PROM) begin
            assert (prom_we) else report_failure("prom_we missing for a PROM byte");
            assert (!prog_we) else report_mismatch("prog_we", prog_we, 0);
            assert (prog_addr == expect_prog_addr(a))
                else report_mismatch("prog_addr", prog_addr, expect_prog_addr(a));
            @(negedge clk);
            assert (!prom_we) else report_failure("prom_we held longer than one cycle");
        end else begin
            assert (prog_we) else report_failure("prog_we missing after ioctl_wr");
            assert (prog_addr == expect_prog_addr(a))
                else report_mismatch("prog_addr", prog_addr, expect_prog_addr(a));
            assert (prog_data == d) else report_mismatch("prog_data", prog_data, d);
            assert (prog_mask == (a[0] ? 2'b01 : 2'b10))
                else report_mismatch("prog_mask", prog_mask, a[0] ? 2'b01 : 2'b10);
            n = 0;
            while (prog_we && n < TMO) begin
                @(negedge clk);
                n++;
            end
            if (prog_we) report_failure("prog_we never dropped after sdram_ack");
        end
    endtask

    task automatic read_slot(input int slot, input logic [23:0] a, input logic [15:0] exp,
                             input logic hit);
        int n;
        @(negedge clk);
        drive_slot(slot, a, 1'b1);
        @(negedge clk);
        if (hit) begin
            assert (slot_ok(slot)) else report_failure("ok late on a cached read");
            assert (!sdram_req) else report_failure("SDRAM read on a cached word");
            // A stray fetch reaches sdram_req two edges after the slot request
            repeat (3) begin
                @(negedge clk);
                assert (!sdram_req) else report_failure("SDRAM read on a cached word");
            end
        end
        n = 0;
        while (!slot_ok(slot) && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!slot_ok(slot)) report_failure("slot ok never rose");
        assert (slot_data(slot) == exp)
            else report_mismatch(data_name(slot), slot_data(slot), exp);
        drive_slot(slot, a, 1'b0);
    endtask

    // Main and object slots requesting together
    task automatic read_pair(input logic [23:0] ma, input logic [15:0] mexp,
                             input logic [23:0] oa, input logic [15:0] oexp);
        int n;
        int main_t;
        int obj_t;
        main_t = -1;
        obj_t  = -1;
        @(negedge clk);
        drive_slot(0, ma, 1'b1);
        drive_slot(3, oa, 1'b1);
        n = 0;
        while ((main_t < 0 || obj_t < 0) && n < TMO) begin
            @(negedge clk);
            n++;
            if (main_ok && main_t < 0) begin
                main_t = n;
                assert (main_data == mexp[7:0]) else report_mismatch("main_data", main_data, mexp);
            end
            if (obj_ok && obj_t < 0) begin
                obj_t = n;
                assert (obj_data == oexp) else report_mismatch("obj_data", obj_data, oexp);
            end
        end
        if (main_t < 0 || obj_t < 0) report_failure("paired read never completed");
        assert (main_t < obj_t) else report_failure("object slot served before main");
        drive_slot(0, ma, 1'b0);
        drive_slot(3, oa, 1'b0);
    endtask

    task automatic read_blocked(input logic [23:0] a, input logic [15:0] exp);
        int n;
        @(negedge clk);
        downloading = 1'b1;
        drive_slot(0, a, 1'b1);
        repeat (20) begin
            @(negedge clk);
            assert (!sdram_req) else report_failure("SDRAM read while downloading");
            assert (!main_ok) else report_failure("main ok while downloading");
        end
        downloading = 1'b0;
        n = 0;
        while (!main_ok && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!main_ok) report_failure("main ok never rose after the download");
        assert (main_data == exp[7:0]) else report_mismatch("main_data", main_data, exp);
        drive_slot(0, a, 1'b0);
    endtask

    initial begin
        for (int i = 0; i < 64; i++) pat[i] = 48'hF00000000000;
        $readmemh("verif/rom_patterns.hex", pat);
        clk = 1'b0;
        rst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr = 1'b0;
        sdram_ack = 1'b0;
        data_rdy = 1'b0;
        data_read = '0;
        drive_slot(0, 24'h0, 1'b0);
        drive_slot(1, 24'h0, 1'b0);
        drive_slot(2, 24'h0, 1'b0);
        drive_slot(3, 24'h0, 1'b0);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        downloading = 1'b1;
        for (int i = 0; i < 64; i++) begin
            case (pat[i][47:44])
                4'h0: download_byte(25'(pat[i][39:16]), pat[i][7:0]);
                4'h1: begin
                    downloading = 1'b0;
                    read_slot(int'(pat[i][43:40]), pat[i][39:16], pat[i][15:0], 1'b0);
                end
                4'h2: read_slot(int'(pat[i][43:40]), pat[i][39:16], pat[i][15:0], 1'b1);
                4'h3: begin
                    read_pair(pat[i][39:16], pat[i][15:0], pat[i+1][39:16], pat[i+1][15:0]);
                    i++;
                end
                4'h4: read_blocked(pat[i][39:16], pat[i][15:0]);
                default: ;
            endcase
        end
        repeat (4) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verif/game_rom_sva.sv
// Handshake checks on the SDRAM read port and the download programming port
`timescale 1ns/1ns
`include "game_macros.svh"

module game_rom_sva #(
    parameter bit READ_PORT = 1'b1   // Read port may not start during a download
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      downloading,
    input logic                      req,
    input logic [`GAME_SDRAM_AW-1:0] addr,
    input logic                      ack,
    input logic                      strobe
);

    // Request and address hold until the SDRAM acknowledges
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (req && !ack) |=> (req && $stable(addr)))
        else $error("request dropped or address moved before acknowledge");

    a_no_read_in_download: assert property (@(posedge clk) disable iff (!rst_n)
        (READ_PORT && $rose(req)) |-> $past(!downloading))
        else $error("SDRAM read started while downloading");

    // PROM strobe and SDRAM write are exclusive
    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(strobe && req))
        else $error("PROM strobe together with SDRAM write");

endmodule

bind rom_arbiter game_rom_sva #(.READ_PORT(1'b1)) arb_sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .downloading (downloading),
    .req         (sdram_req),
    .addr        (sdram_addr),
    .ack         (sdram_ack),
    .strobe      (1'b0)
);

bind rom_loader game_rom_sva #(.READ_PORT(1'b0)) loader_sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .downloading (downloading),
    .req         (prog_we),
    .addr        (prog_addr),
    .ack         (sdram_ack),
    .strobe      (prom_we)
);

// File: logic/game_rom_top.sv
// Game ROM subsystem joining the download mapper, four cached slots and the SDRAM arbiter
`timescale 1ns/1ns
`include "game_macros.svh"

module game_rom_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      downloading,
    input  logic [`GAME_IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                ioctl_dout,
    input  logic                      ioctl_wr,
    output logic [`GAME_SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                prog_data,
    output logic [1:0]                prog_mask,
    output logic                      prog_we,
    output logic                      prom_we,
    output logic                      sdram_req,
    output logic [`GAME_SDRAM_AW-1:0] sdram_addr,
    input  logic                      sdram_ack,
    input  logic                      data_rdy,
    input  logic [31:0]               data_read,
    input  logic                      main_cs,
    input  logic [`MAIN_SLOT_AW-1:0]  main_addr,
    output logic [7:0]                main_data,
    output logic                      main_ok,
    input  logic                      snd_cs,
    input  logic [`SND_SLOT_AW-1:0]   snd_addr,
    output logic [7:0]                snd_data,
    output logic                      snd_ok,
    input  logic                      char_cs,
    input  logic [`CHAR_SLOT_AW-1:0]  char_addr,
    output logic [7:0]                char_data,
    output logic                      char_ok,
    input  logic                      obj_cs,
    input  logic [`OBJ_SLOT_AW-1:0]   obj_addr,
    output logic [15:0]               obj_data,
    output logic                      obj_ok
);

    localparam int SAW = `GAME_SDRAM_AW;

    // Code regions sit at half their byte address
    localparam logic [SAW-1:0] MAIN_OFF = SAW'(`MAIN_START >> 1);
    localparam logic [SAW-1:0] SND_OFF  = SAW'(`SND_START >> 1);
    localparam logic [SAW-1:0] CHAR_OFF = SAW'(`CHAR_START >> 1);

    rom_req_if main_if ();
    rom_req_if snd_if ();
    rom_req_if char_if ();
    rom_req_if obj_if ();

    rom_loader u_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    rom_slot #(.AW(`MAIN_SLOT_AW), .DW(8), .OFFSET(MAIN_OFF)) u_main (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (main_cs),
        .addr  (main_addr),
        .data  (main_data),
        .ok    (main_ok),
        .bus   (main_if.slot)
    );

    rom_slot #(.AW(`SND_SLOT_AW), .DW(8), .OFFSET(SND_OFF)) u_snd (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (snd_cs),
        .addr  (snd_addr),
        .data  (snd_data),
        .ok    (snd_ok),
        .bus   (snd_if.slot)
    );

    rom_slot #(.AW(`CHAR_SLOT_AW), .DW(8), .OFFSET(CHAR_OFF)) u_char (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (char_cs),
        .addr  (char_addr),
        .data  (char_data),
        .ok    (char_ok),
        .bus   (char_if.slot)
    );

    // Objects were relocated during the download
    rom_slot #(.AW(`OBJ_SLOT_AW), .DW(16), .OFFSET(`OBJ_SDRAM)) u_obj (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (obj_cs),
        .addr  (obj_addr),
        .data  (obj_data),
        .ok    (obj_ok),
        .bus   (obj_if.slot)
    );

    rom_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .main_bus    (main_if.arbiter),
        .snd_bus     (snd_if.arbiter),
        .char_bus    (char_if.arbiter),
        .obj_bus     (obj_if.arbiter),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read)
    );

endmodule

// File: logic/rom_arbiter.sv
// Fixed-priority arbiter sharing one SDRAM read port among four ROM slots
`timescale 1ns/1ns
`include "game_macros.svh"

module rom_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      downloading,
    rom_req_if.arbiter                main_bus,
    rom_req_if.arbiter                snd_bus,
    rom_req_if.arbiter                char_bus,
    rom_req_if.arbiter                obj_bus,
    output logic                      sdram_req,
    output logic [`GAME_SDRAM_AW-1:0] sdram_addr,
    input  logic                      sdram_ack,
    input  logic                      data_rdy,
    input  logic [31:0]               data_read
);

    logic [3:0]                req_vec;
    logic [1:0]                win_sel;
    logic [`GAME_SDRAM_AW-1:0] win_addr;
    logic [1:0]                cur_sel;     // Slot owning the read in flight
    logic                      busy;
    logic                      accept;
    logic                      done;
    logic [3:0]                grant_vec;
    logic [3:0]                rdy_vec;
    game_rom_pkg::sdram_word_t rd_word;

    assign req_vec = {obj_bus.req, char_bus.req, snd_bus.req, main_bus.req};

    // Main first, objects last
    always_comb begin
        if (main_bus.req) begin
            win_sel  = 2'd0;
            win_addr = main_bus.addr;
        end else if (snd_bus.req) begin
            win_sel  = 2'd1;
            win_addr = snd_bus.addr;
        end else if (char_bus.req) begin
            win_sel  = 2'd2;
            win_addr = char_bus.addr;
        end else begin
            win_sel  = 2'd3;
            win_addr = obj_bus.addr;
        end
    end

    assign accept = !busy && !downloading && |req_vec;
    assign done   = busy && !sdram_req && data_rdy;  // Data only after the ack

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            sdram_req <= 1'b0;
            grant_vec <= '0;
        end else begin
            grant_vec <= '0;
            if (accept) begin
                busy               <= 1'b1;
                sdram_req          <= 1'b1;
                grant_vec[win_sel] <= 1'b1;
            end else begin
                if (sdram_req && sdram_ack) begin
                    sdram_req <= 1'b0;
                end
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_sel    <= win_sel;
            sdram_addr <= win_addr;
        end
    end

    assign rdy_vec = done ? (4'b0001 << cur_sel) : 4'b0000;
    assign rd_word = data_read;

    assign main_bus.grant = grant_vec[0];
    assign snd_bus.grant  = grant_vec[1];
    assign char_bus.grant = grant_vec[2];
    assign obj_bus.grant  = grant_vec[3];

    assign main_bus.rdy   = rdy_vec[0];
    assign snd_bus.rdy    = rdy_vec[1];
    assign char_bus.rdy   = rdy_vec[2];
    assign obj_bus.rdy    = rdy_vec[3];

    // Read word goes only to the owner
    assign main_bus.data  = (cur_sel == 2'd0) ? rd_word : '0;
    assign snd_bus.data   = (cur_sel == 2'd1) ? rd_word : '0;
    assign char_bus.data  = (cur_sel == 2'd2) ? rd_word : '0;
    assign obj_bus.data   = (cur_sel == 2'd3) ? rd_word : '0;

endmodule

// File: logic/rom_slot.sv
// Cached ROM client fetching one 32-bit SDRAM word per miss
`timescale 1ns/1ns
`include "game_macros.svh"

module rom_slot #(
    parameter int                        AW     = 18,
    parameter int                        DW     = 8,
    parameter logic [`GAME_SDRAM_AW-1:0] OFFSET = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic [DW-1:0] data,
    output logic          ok,
    rom_req_if.slot       bus
);

    localparam int SAW = `GAME_SDRAM_AW;
    localparam int WSH = (DW == 8) ? 2 : 1;  // Address bits within one cached word

    game_rom_pkg::sdram_word_t cache;
    logic [SAW-1:0]            cache_addr;   // Tag
    logic                      cache_valid;
    logic                      in_flight;    // Granted, waiting for rdy
    logic [SAW-1:0]            addr_ext;
    logic [SAW-1:0]            need_addr;
    logic                      hit;
    logic                      start_req;
    logic                      fill;
    logic [DW-1:0]             sel_data;

    assign addr_ext  = SAW'(addr);
    assign need_addr = OFFSET + ((addr_ext >> WSH) << 1);  // Even word
    assign hit       = cache_valid && (cache_addr == need_addr);
    assign start_req = cs && !hit && !bus.req;
    assign fill      = bus.rdy && in_flight;

    generate
        if (DW == 8) begin : g_byte
            assign sel_data = cache.bytes[addr[1:0]];
        end else begin : g_half
            assign sel_data = cache.halves[addr[0]];
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.req     <= 1'b0;
            in_flight   <= 1'b0;
            cache_valid <= 1'b0;
            ok          <= 1'b0;
        end else begin
            ok <= cs && hit;
            if (bus.grant) begin
                in_flight <= 1'b1;
            end
            if (fill) begin
                bus.req     <= 1'b0;
                in_flight   <= 1'b0;
                cache_valid <= 1'b1;
            end else if (start_req) begin
                bus.req <= 1'b1;
            end
        end
    end

    // Address is frozen while the request is pending
    always_ff @(posedge clk) begin
        if (start_req) begin
            bus.addr <= need_addr;
        end
        if (fill) begin
            cache      <= bus.data;
            cache_addr <= bus.addr;
        end
        data <= sel_data;
    end

endmodule

// File: logic/rom_loader.sv
// Download mapper turning ioctl bytes into SDRAM programming writes and PROM strobes
`timescale 1ns/1ns
`include "game_macros.svh"

module rom_loader (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      downloading,
    input  logic [`GAME_IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                ioctl_dout,
    input  logic                      ioctl_wr,
    input  logic                      sdram_ack,
    output logic [`GAME_SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                prog_data,
    output logic [1:0]                prog_mask,
    output logic                      prog_we,
    output logic                      prom_we
);

    game_rom_pkg::region_t     region;
    logic [`GAME_IOCTL_AW-1:0] region_base;  // First byte of the region
    logic [`GAME_SDRAM_AW-1:0] sdram_base;   // Word base after relocation
    logic [`GAME_IOCTL_AW-1:0] rel_addr;
    logic                      wr_en;

    always_comb begin
        if (ioctl_addr < `SCR_START) begin
            region      = game_rom_pkg::REG_CODE;   // Main, sound and char stay in place
            region_base = `MAIN_START;
            sdram_base  = '0;
        end else if (ioctl_addr < `OBJ_START) begin
            region      = game_rom_pkg::REG_SCROLL;
            region_base = `SCR_START;
            sdram_base  = `SCR_SDRAM;
        end else if (ioctl_addr < `PROM_START) begin
            region      = game_rom_pkg::REG_OBJECT;
            region_base = `OBJ_START;
            sdram_base  = `OBJ_SDRAM;
        end else if (ioctl_addr < `ROM_END) begin
            region      = game_rom_pkg::REG_PROM;
            region_base = `PROM_START;
            sdram_base  = '0;
        end else begin
            region      = game_rom_pkg::REG_NONE;
            region_base = `ROM_END;
            sdram_base  = '0;
        end
    end

    assign rel_addr = ioctl_addr - region_base;
    assign wr_en    = downloading && ioctl_wr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;   // Single cycle strobe
            if (prog_we && sdram_ack) begin
                prog_we <= 1'b0;
            end
            if (wr_en) begin
                case (region)
                    game_rom_pkg::REG_CODE,
                    game_rom_pkg::REG_SCROLL,
                    game_rom_pkg::REG_OBJECT: prog_we <= 1'b1;
                    game_rom_pkg::REG_PROM:   prom_we <= 1'b1;
                    default:                  ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && region != game_rom_pkg::REG_NONE) begin
            prog_data <= ioctl_dout;
            prog_mask <= {~ioctl_addr[0], ioctl_addr[0]};  // Low on the byte written
            if (region == game_rom_pkg::REG_PROM) begin
                prog_addr <= rel_addr[`GAME_SDRAM_AW-1:0];  // PROM offset
            end else begin
                prog_addr <= rel_addr[`GAME_SDRAM_AW:1] + sdram_base;
            end
        end
    end

endmodule

// File: logic/rom_req_if.sv
// Request channel between one ROM slot and the SDRAM read arbiter
`timescale 1ns/1ns
`include "game_macros.svh"

interface rom_req_if;

    logic                          req;    // Held until rdy
    logic [`GAME_SDRAM_AW-1:0]     addr;   // Even word address
    logic                          grant;  // Request accepted
    logic                          rdy;    // Word delivered
    game_rom_pkg::sdram_word_t     data;

    modport slot (
        output req,
        output addr,
        input  grant,
        input  rdy,
        input  data
    );

    modport arbiter (
        input  req,
        input  addr,
        output grant,
        output rdy,
        output data
    );

endinterface

// File: logic/game_rom_pkg.sv
// Shared types for the ROM download and SDRAM read path
package game_rom_pkg;

    // One 32-bit SDRAM read, seen as bytes by 8-bit clients or halves by 16-bit ones
    typedef union packed {
        logic [3:0][7:0]  bytes;    // Byte 0 in bits 7:0
        logic [1:0][15:0] halves;   // Half 0 in bits 15:0
    } sdram_word_t;

    // Download region of one ioctl byte
    typedef enum logic [2:0] {
        REG_CODE,
        REG_SCROLL,
        REG_OBJECT,
        REG_PROM,
        REG_NONE
    } region_t;

endpackage

// File: logic/game_macros.svh
// Address widths, download region map and SDRAM relocation bases for the game ROM path
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// SDRAM word address and download byte address widths
`define GAME_SDRAM_AW 22
`define GAME_IOCTL_AW 25

// Download byte start addresses of each region
`define MAIN_START    25'h0000000
`define SND_START     25'h0028000
`define CHAR_START    25'h0080000
`define SCR_START     25'h0090000
`define OBJ_START     25'h00D0000
`define PROM_START    25'h0190000
`define ROM_END       25'h0190200   // Priority PROM ends here

// Relocated 16-bit word bases in SDRAM
`define SCR_SDRAM     22'h060000
`define OBJ_SDRAM     22'h080000

// Slot address widths
`define MAIN_SLOT_AW  18
`define SND_SLOT_AW   15
`define CHAR_SLOT_AW  16
`define OBJ_SLOT_AW   19

`endif
